/* include/llc_consts.svh */
`ifndef LLC_CONSTS_SVH
`define LLC_CONSTS_SVH

// set addressing
`define LLC_SET_BITS 6

// associativity and the width of a way number
`define LLC_WAYS 4
`define LLC_WAY_BITS 2

// banks are picked by the upper set bits
`define LLC_BANK_BITS 1
`define LLC_BANKS 2

// row inside a bank, the set bits left below the bank bits
`define LLC_ROW_BITS (`LLC_SET_BITS - `LLC_BANK_BITS)

// per-way payload and metadata widths
`define LLC_TAG_BITS 20
`define LLC_LINE_BITS 128
`define LLC_SHARERS_BITS 16
`define LLC_STATE_BITS 3

`endif

/* design/llc_pkg.sv */
`default_nettype none

`include "llc_consts.svh"

package llc_pkg;

    // addressing
    typedef logic [`LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [`LLC_WAY_BITS-1:0] llc_way_t;
    typedef logic [`LLC_BANK_BITS-1:0] llc_bank_t;
    typedef logic [`LLC_ROW_BITS-1:0] llc_row_t;

    // stored fields
    typedef logic [`LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [`LLC_LINE_BITS-1:0] line_t;
    typedef logic [`LLC_SHARERS_BITS-1:0] sharers_t;

    // coherence state of one way
    // invalid must stay at zero, reset of the read registers relies on it
    typedef enum logic [`LLC_STATE_BITS-1:0] {
        invalid   = 3'd0,
        valid     = 3'd1,
        shared    = 3'd2,
        exclusive = 3'd3,
        modified  = 3'd4,
        sd        = 3'd5,
        sharers_d = 3'd6
    } llc_state_t;

endpackage

`default_nettype wire

/* design/llc_wr_if.sv */
`timescale 1ns/1ns
`default_nettype none

`include "llc_consts.svh"

interface llc_wr_if;

    // target of the write
    llc_pkg::llc_bank_t bank;
    llc_pkg::llc_row_t row;

    // per-way strobes, one cycle each
    logic [`LLC_WAYS-1:0] line_we;
    logic [`LLC_WAYS-1:0] meta_we;
    logic evict_we;

    // write fields, shared by all ways
    llc_pkg::line_t line;
    llc_pkg::llc_tag_t tag;
    llc_pkg::llc_state_t state;
    logic dirty;
    llc_pkg::sharers_t sharers;
    llc_pkg::llc_way_t evict_way;

    modport decoder (
        output bank, row, line_we, meta_we, evict_we,
        output line, tag, state, dirty, sharers, evict_way
    );

    modport banks (
        input bank, row, line_we, meta_we, evict_we,
        input line, tag, state, dirty, sharers, evict_way
    );

endinterface

`default_nettype wire

/* design/llc_rd_if.sv */
`timescale 1ns/1ns
`default_nettype none

`include "llc_consts.svh"

interface llc_rd_if;

    // bank of the last read set
    llc_pkg::llc_bank_t bank_q;

    // raw read words of every bank
    llc_pkg::line_t line_q [`LLC_BANKS][`LLC_WAYS];
    llc_pkg::llc_tag_t tag_q [`LLC_BANKS][`LLC_WAYS];
    llc_pkg::llc_state_t state_q [`LLC_BANKS][`LLC_WAYS];
    logic dirty_q [`LLC_BANKS][`LLC_WAYS];
    llc_pkg::sharers_t sharers_q [`LLC_BANKS][`LLC_WAYS];
    llc_pkg::llc_way_t evict_q [`LLC_BANKS];

    modport banks (
        output bank_q, line_q, tag_q, state_q, dirty_q, sharers_q, evict_q
    );

    modport selector (
        input bank_q, line_q, tag_q, state_q, dirty_q, sharers_q, evict_q
    );

endinterface

`default_nettype wire

/* design/llc_wr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "llc_consts.svh"

module llc_wr_decode (
    input  var llc_pkg::llc_set_t    set_in,
    input  var llc_pkg::llc_way_t    way,
    input  var logic                 wr_en,
    input  var logic [`LLC_WAYS-1:0] wr_rst_flush,
    input  var logic                 wr_en_evict_way,
    input  var llc_pkg::line_t       wr_data_line,
    input  var llc_pkg::llc_tag_t    wr_data_tag,
    input  var llc_pkg::llc_state_t  wr_data_state,
    input  var logic                 wr_data_dirty_bit,
    input  var llc_pkg::sharers_t    wr_data_sharers,
    input  var llc_pkg::llc_way_t    wr_data_evict_way,
    llc_wr_if.decoder                wr
);

    // upper set bits pick the bank, the rest address a row in it
    assign wr.bank = set_in[`LLC_SET_BITS-1 -: `LLC_BANK_BITS];
    assign wr.row = set_in[`LLC_ROW_BITS-1:0];

    // a full write hits one way, a flush bit rewrites only the metadata of its way
    always_comb begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
            wr.line_we[w] = wr_en && (way == llc_pkg::llc_way_t'(w));
            wr.meta_we[w] = (wr_en && (way == llc_pkg::llc_way_t'(w))) || wr_rst_flush[w];
        end
    end

    assign wr.evict_we = wr_en_evict_way;

    assign wr.line = wr_data_line;
    assign wr.tag = wr_data_tag;
    assign wr.state = wr_data_state;
    assign wr.dirty = wr_data_dirty_bit;
    assign wr.sharers = wr_data_sharers;
    assign wr.evict_way = wr_data_evict_way;

    // the state that lands in any way must be one of the defined encodings
    always_comb begin
        if (|wr.meta_we) begin
            a_state_legal: assert final (wr_data_state <= llc_pkg::sharers_d)
                else $error("state write with undefined encoding %0d", wr_data_state);
        end
    end

endmodule

`default_nettype wire

/* design/llc_way_banks.sv */
`timescale 1ns/1ns
`default_nettype none

`include "llc_consts.svh"

module llc_way_banks (
    input  var logic              clk,
    input  var logic              rst_n,
    input  var logic              rd_en,
    input  var llc_pkg::llc_set_t set_in,
    llc_wr_if.banks               wr,
    llc_rd_if.banks               rd
);

    // storage, one row array per bank and way for every field
    llc_pkg::line_t line_mem [`LLC_BANKS][`LLC_WAYS][(1 << `LLC_ROW_BITS)];
    llc_pkg::llc_tag_t tag_mem [`LLC_BANKS][`LLC_WAYS][(1 << `LLC_ROW_BITS)];
    llc_pkg::llc_state_t state_mem [`LLC_BANKS][`LLC_WAYS][(1 << `LLC_ROW_BITS)];
    logic dirty_mem [`LLC_BANKS][`LLC_WAYS][(1 << `LLC_ROW_BITS)];
    llc_pkg::sharers_t sharers_mem [`LLC_BANKS][`LLC_WAYS][(1 << `LLC_ROW_BITS)];
    llc_pkg::llc_way_t evict_mem [`LLC_BANKS][(1 << `LLC_ROW_BITS)];

    llc_pkg::llc_bank_t rd_bank;
    llc_pkg::llc_row_t rd_row;

    assign rd_bank = set_in[`LLC_SET_BITS-1 -: `LLC_BANK_BITS];
    assign rd_row = set_in[`LLC_ROW_BITS-1:0];

    always_ff @(posedge clk) begin
        for (int b = 0; b < `LLC_BANKS; b++) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                if (wr.bank == llc_pkg::llc_bank_t'(b) && wr.line_we[w]) begin
                    line_mem[b][w][wr.row] <= wr.line;
                    tag_mem[b][w][wr.row] <= wr.tag;
                end
                if (wr.bank == llc_pkg::llc_bank_t'(b) && wr.meta_we[w]) begin
                    state_mem[b][w][wr.row] <= wr.state;
                    dirty_mem[b][w][wr.row] <= wr.dirty;
                    sharers_mem[b][w][wr.row] <= wr.sharers;
                end
            end
            if (wr.bank == llc_pkg::llc_bank_t'(b) && wr.evict_we) begin
                evict_mem[b][wr.row] <= wr.evict_way;
            end
        end
    end

    // every bank reads the same row, the selector keeps only bank_q
    // nonblocking writes above mean a read on a write edge sees the old row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd.bank_q <= '0;
            for (int b = 0; b < `LLC_BANKS; b++) begin
                for (int w = 0; w < `LLC_WAYS; w++) begin
                    rd.line_q[b][w] <= '0;
                    rd.tag_q[b][w] <= '0;
                    rd.state_q[b][w] <= llc_pkg::invalid;
                    rd.dirty_q[b][w] <= 1'b0;
                    rd.sharers_q[b][w] <= '0;
                end
                rd.evict_q[b] <= '0;
            end
        end else if (rd_en) begin
            rd.bank_q <= rd_bank;
            for (int b = 0; b < `LLC_BANKS; b++) begin
                for (int w = 0; w < `LLC_WAYS; w++) begin
                    rd.line_q[b][w] <= line_mem[b][w][rd_row];
                    rd.tag_q[b][w] <= tag_mem[b][w][rd_row];
                    rd.state_q[b][w] <= state_mem[b][w][rd_row];
                    rd.dirty_q[b][w] <= dirty_mem[b][w][rd_row];
                    rd.sharers_q[b][w] <= sharers_mem[b][w][rd_row];
                end
                rd.evict_q[b] <= evict_mem[b][rd_row];
            end
        end
    end

    // a line and tag write without its metadata would leave a stale state on new data
    for (genvar w = 0; w < `LLC_WAYS; w++) begin : g_we_chk
        a_line_with_meta: assert property (
            @(posedge clk) disable iff (!rst_n)
            wr.line_we[w] |-> wr.meta_we[w]
        ) else $error("line write on way %0d without metadata write", w);
    end

endmodule

`default_nettype wire

/* design/llc_rd_select.sv */
`timescale 1ns/1ns
`default_nettype none

`include "llc_consts.svh"

module llc_rd_select (
    llc_rd_if.selector               rd,
    output var llc_pkg::line_t       rd_data_line      [`LLC_WAYS],
    output var llc_pkg::llc_tag_t    rd_data_tag       [`LLC_WAYS],
    output var llc_pkg::llc_state_t  rd_data_state     [`LLC_WAYS],
    output var logic                 rd_data_dirty_bit [`LLC_WAYS],
    output var llc_pkg::sharers_t    rd_data_sharers   [`LLC_WAYS],
    output var llc_pkg::llc_way_t    rd_data_evict_way
);

    // all ways of the addressed bank go out together
    always_comb begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
            rd_data_line[w] = rd.line_q[rd.bank_q][w];
            rd_data_tag[w] = rd.tag_q[rd.bank_q][w];
            rd_data_state[w] = rd.state_q[rd.bank_q][w];
            rd_data_dirty_bit[w] = rd.dirty_q[rd.bank_q][w];
            rd_data_sharers[w] = rd.sharers_q[rd.bank_q][w];
        end
    end

    assign rd_data_evict_way = rd.evict_q[rd.bank_q];

endmodule

`default_nettype wire

/* design/llc_localmem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "llc_consts.svh"

module llc_localmem (
    input  var logic                 clk,
    input  var logic                 rst_n,
    input  var logic                 rd_en,
    input  var llc_pkg::llc_set_t    set_in,
    input  var llc_pkg::llc_way_t    way,

    // write side
    input  var llc_pkg::line_t       wr_data_line,
    input  var llc_pkg::llc_tag_t    wr_data_tag,
    input  var llc_pkg::sharers_t    wr_data_sharers,
    input  var logic                 wr_data_dirty_bit,
    input  var llc_pkg::llc_way_t    wr_data_evict_way,
    input  var llc_pkg::llc_state_t  wr_data_state,
    input  var logic                 wr_en,
    input  var logic [`LLC_WAYS-1:0] wr_rst_flush,
    input  var logic                 wr_en_evict_way,

    // read side, valid one cycle after rd_en
    output var llc_pkg::line_t       rd_data_line      [`LLC_WAYS],
    output var llc_pkg::llc_tag_t    rd_data_tag       [`LLC_WAYS],
    output var llc_pkg::sharers_t    rd_data_sharers   [`LLC_WAYS],
    output var logic                 rd_data_dirty_bit [`LLC_WAYS],
    output var llc_pkg::llc_way_t    rd_data_evict_way,
    output var llc_pkg::llc_state_t  rd_data_state     [`LLC_WAYS]
);

    llc_wr_if wr_bus ();
    llc_rd_if rd_bus ();

    llc_wr_decode u_wr_decode (
        .set_in            (set_in),
        .way               (way),
        .wr_en             (wr_en),
        .wr_rst_flush      (wr_rst_flush),
        .wr_en_evict_way   (wr_en_evict_way),
        .wr_data_line      (wr_data_line),
        .wr_data_tag       (wr_data_tag),
        .wr_data_state     (wr_data_state),
        .wr_data_dirty_bit (wr_data_dirty_bit),
        .wr_data_sharers   (wr_data_sharers),
        .wr_data_evict_way (wr_data_evict_way),
        .wr                (wr_bus.decoder)
    );

    llc_way_banks u_way_banks (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd_en  (rd_en),
        .set_in (set_in),
        .wr     (wr_bus.banks),
        .rd     (rd_bus.banks)
    );

    llc_rd_select u_rd_select (
        .rd                (rd_bus.selector),
        .rd_data_line      (rd_data_line),
        .rd_data_tag       (rd_data_tag),
        .rd_data_state     (rd_data_state),
        .rd_data_dirty_bit (rd_data_dirty_bit),
        .rd_data_sharers   (rd_data_sharers),
        .rd_data_evict_way (rd_data_evict_way)
    );

endmodule

`default_nettype wire

/* dv/tb_llc_localmem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "llc_consts.svh"

module tb_llc_localmem;

    localparam int SETS = 1 << `LLC_SET_BITS;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int RANDOM_ROUNDS = 200;

    logic clk;
    logic rst_n;
    logic rd_en;
    llc_pkg::llc_set_t set_in;
    llc_pkg::llc_way_t way;
    llc_pkg::line_t wr_data_line;
    llc_pkg::llc_tag_t wr_data_tag;
    llc_pkg::sharers_t wr_data_sharers;
    logic wr_data_dirty_bit;
    llc_pkg::llc_way_t wr_data_evict_way;
    llc_pkg::llc_state_t wr_data_state;
    logic wr_en;
    logic [`LLC_WAYS-1:0] wr_rst_flush;
    logic wr_en_evict_way;

    llc_pkg::line_t rd_data_line [`LLC_WAYS];
    llc_pkg::llc_tag_t rd_data_tag [`LLC_WAYS];
    llc_pkg::sharers_t rd_data_sharers [`LLC_WAYS];
    logic rd_data_dirty_bit [`LLC_WAYS];
    llc_pkg::llc_way_t rd_data_evict_way;
    llc_pkg::llc_state_t rd_data_state [`LLC_WAYS];

    // shadow of the storage indexed by the full set number
    llc_pkg::line_t sh_line [SETS][`LLC_WAYS];
    llc_pkg::llc_tag_t sh_tag [SETS][`LLC_WAYS];
    llc_pkg::llc_state_t sh_state [SETS][`LLC_WAYS];
    logic sh_dirty [SETS][`LLC_WAYS];
    llc_pkg::sharers_t sh_sharers [SETS][`LLC_WAYS];
    llc_pkg::llc_way_t sh_evict [SETS];

    // expected read set captured on the rd_en edge
    llc_pkg::line_t exp_line [`LLC_WAYS];
    llc_pkg::llc_tag_t exp_tag [`LLC_WAYS];
    llc_pkg::llc_state_t exp_state [`LLC_WAYS];
    logic exp_dirty [`LLC_WAYS];
    llc_pkg::sharers_t exp_sharers [`LLC_WAYS];
    llc_pkg::llc_way_t exp_evict;

    logic read_seen;
    logic check_pending;
    logic [127:0] out_or;
    string test_name;
    integer seed;

    llc_localmem uut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // write rules applied to the shadow while reads see the pre-edge contents
    always @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                exp_line[w] <= sh_line[set_in][w];
                exp_tag[w] <= sh_tag[set_in][w];
                exp_state[w] <= sh_state[set_in][w];
                exp_dirty[w] <= sh_dirty[set_in][w];
                exp_sharers[w] <= sh_sharers[set_in][w];
            end
            exp_evict <= sh_evict[set_in];
        end
        for (int w = 0; w < `LLC_WAYS; w++) begin
            if (wr_en && way == llc_pkg::llc_way_t'(w)) begin
                sh_line[set_in][w] <= wr_data_line;
                sh_tag[set_in][w] <= wr_data_tag;
            end
            if ((wr_en && way == llc_pkg::llc_way_t'(w)) || wr_rst_flush[w]) begin
                sh_state[set_in][w] <= wr_data_state;
                sh_dirty[set_in][w] <= wr_data_dirty_bit;
                sh_sharers[set_in][w] <= wr_data_sharers;
            end
        end
        if (wr_en_evict_way) begin
            sh_evict[set_in] <= wr_data_evict_way;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_seen <= 1'b0;
            check_pending <= 1'b0;
        end else begin
            if (rd_en) begin
                read_seen <= 1'b1;
            end
            check_pending <= rd_en;
        end
    end

    // every output bit folded together so it is zero only when all outputs are zero
    always_comb begin
        out_or = 128'(rd_data_evict_way);
        for (int w = 0; w < `LLC_WAYS; w++) begin
            out_or = out_or | rd_data_line[w] | 128'(rd_data_tag[w]) | 128'(rd_data_state[w])
                | 128'(rd_data_dirty_bit[w]) | 128'(rd_data_sharers[w]);
        end
    end

    task automatic stop_on_failure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first failing check");
    endtask

    task automatic report_mismatch(input string field, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("** Error [%s] %s: expected %h, actual %h", test_name, field, expected, actual);
        stop_on_failure();
    endtask

    a_reset_zero: assert property (
        @(posedge clk) disable iff (!rst_n) !read_seen |-> out_or == '0
    ) else report_mismatch("outputs before first read", '0, $sampled(out_or));

    for (genvar w = 0; w < `LLC_WAYS; w++) begin : g_way_chk
        a_line: assert property (
            @(posedge clk) disable iff (!rst_n) rd_en |=> rd_data_line[w] === exp_line[w]
        ) else report_mismatch($sformatf("way %0d line", w), $sampled(exp_line[w]),
                               $sampled(rd_data_line[w]));
        a_tag: assert property (
            @(posedge clk) disable iff (!rst_n) rd_en |=> rd_data_tag[w] === exp_tag[w]
        ) else report_mismatch($sformatf("way %0d tag", w), $sampled(exp_tag[w]),
                               $sampled(rd_data_tag[w]));
        a_state: assert property (
            @(posedge clk) disable iff (!rst_n) rd_en |=> rd_data_state[w] === exp_state[w]
        ) else report_mismatch($sformatf("way %0d state", w), $sampled(exp_state[w]),
                               $sampled(rd_data_state[w]));
        a_dirty: assert property (
            @(posedge clk) disable iff (!rst_n) rd_en |=> rd_data_dirty_bit[w] === exp_dirty[w]
        ) else report_mismatch($sformatf("way %0d dirty", w), $sampled(exp_dirty[w]),
                               $sampled(rd_data_dirty_bit[w]));
        a_sharers: assert property (
            @(posedge clk) disable iff (!rst_n) rd_en |=> rd_data_sharers[w] === exp_sharers[w]
        ) else report_mismatch($sformatf("way %0d sharers", w), $sampled(exp_sharers[w]),
                               $sampled(rd_data_sharers[w]));
    end

    a_evict: assert property (
        @(posedge clk) disable iff (!rst_n) rd_en |=> rd_data_evict_way === exp_evict
    ) else report_mismatch("evict way", $sampled(exp_evict), $sampled(rd_data_evict_way));

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic randomize_fields();
        wr_data_line = {$random(seed), $random(seed), $random(seed), $random(seed)};
        wr_data_tag = llc_pkg::llc_tag_t'($random(seed));
        wr_data_state = llc_pkg::llc_state_t'($unsigned($random(seed)) % 7);
        wr_data_dirty_bit = 1'($random(seed));
        wr_data_sharers = llc_pkg::sharers_t'($random(seed));
        wr_data_evict_way = llc_pkg::llc_way_t'($random(seed));
    endtask

    task automatic wait_read_checked();
        int cycles;
        cycles = 0;
        while (check_pending && cycles < TIMEOUT_CYCLES) begin
            next_cycle();
            cycles++;
        end
        if (check_pending) begin
            $display("timeout: a read was not checked within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    endtask

    task automatic write_way(input llc_pkg::llc_set_t s, input llc_pkg::llc_way_t w);
        set_in = s;
        way = w;
        wr_en = 1'b1;
        next_cycle();
        wr_en = 1'b0;
    endtask

    task automatic flush_ways(input llc_pkg::llc_set_t s, input logic [`LLC_WAYS-1:0] mask);
        set_in = s;
        wr_rst_flush = mask;
        next_cycle();
        wr_rst_flush = '0;
    endtask

    task automatic write_evict_way(input llc_pkg::llc_set_t s);
        set_in = s;
        wr_en_evict_way = 1'b1;
        next_cycle();
        wr_en_evict_way = 1'b0;
    endtask

    task automatic read_set(input llc_pkg::llc_set_t s);
        set_in = s;
        rd_en = 1'b1;
        next_cycle();
        rd_en = 1'b0;
        wait_read_checked();
    endtask

    initial begin
        llc_pkg::llc_set_t s0;
        llc_pkg::llc_set_t s1;
        seed = 32'h689463be;
        rst_n = 1'b0;
        rd_en = 1'b0;
        set_in = '0;
        way = '0;
        wr_data_line = '0;
        wr_data_tag = '0;
        wr_data_sharers = '0;
        wr_data_dirty_bit = 1'b0;
        wr_data_evict_way = '0;
        wr_data_state = llc_pkg::invalid;
        wr_en = 1'b0;
        wr_rst_flush = '0;
        wr_en_evict_way = 1'b0;
        test_name = "reset";
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        // outputs must stay zero over idle edges until the first read
        repeat (3) next_cycle();

        // storage is undefined after reset, so give every field a value first
        test_name = "fill";
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                randomize_fields();
                write_way(llc_pkg::llc_set_t'(s), llc_pkg::llc_way_t'(w));
            end
            write_evict_way(llc_pkg::llc_set_t'(s));
        end

        test_name = "write_all_fields";
        s0 = llc_pkg::llc_set_t'($random(seed));
        randomize_fields();
        write_way(s0, llc_pkg::llc_way_t'($random(seed)));
        read_set(s0);

        test_name = "flush";
        randomize_fields();
        flush_ways(s0, 4'b1011);
        read_set(s0);

        // same row bits with a different bank bit
        test_name = "bank_select";
        s0 = llc_pkg::llc_set_t'($unsigned($random(seed)) % (SETS / `LLC_BANKS));
        s1 = s0;
        s1[`LLC_SET_BITS-1] = 1'b1;
        randomize_fields();
        write_way(s0, 2'd1);
        randomize_fields();
        write_way(s1, 2'd1);
        read_set(s0);
        read_set(s1);

        test_name = "evict_way";
        randomize_fields();
        write_evict_way(s1);
        read_set(s1);

        // read and every kind of write on the same edge
        test_name = "read_during_write";
        randomize_fields();
        set_in = s1;
        way = 2'd2;
        wr_en = 1'b1;
        wr_rst_flush = 4'b0101;
        wr_en_evict_way = 1'b1;
        rd_en = 1'b1;
        next_cycle();
        wr_en = 1'b0;
        wr_rst_flush = '0;
        wr_en_evict_way = 1'b0;
        rd_en = 1'b0;
        wait_read_checked();
        read_set(s1);

        test_name = "random_traffic";
        for (int i = 0; i < RANDOM_ROUNDS; i++) begin
            randomize_fields();
            s0 = llc_pkg::llc_set_t'($random(seed));
            set_in = s0;
            way = llc_pkg::llc_way_t'($random(seed));
            wr_en = 1'($random(seed));
            wr_rst_flush = 4'($random(seed));
            wr_en_evict_way = 1'($random(seed));
            rd_en = 1'($random(seed));
            next_cycle();
            wr_en = 1'b0;
            wr_rst_flush = '0;
            wr_en_evict_way = 1'b0;
            rd_en = 1'b0;
            wait_read_checked();
            read_set(s0);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
design/llc_pkg.sv
design/llc_wr_if.sv
design/llc_rd_if.sv
design/llc_wr_decode.sv
design/llc_way_banks.sv
design/llc_rd_select.sv
design/llc_localmem.sv
dv/tb_llc_localmem.sv

/* Bender.yml */
package:
  name: llc_localmem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/llc_pkg.sv
      - design/llc_wr_if.sv
      - design/llc_rd_if.sv
      - design/llc_wr_decode.sv
      - design/llc_way_banks.sv
      - design/llc_rd_select.sv
      - design/llc_localmem.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_llc_localmem.sv
